// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // matrix unit output geometry
    localparam int MXU_ROWS   = 16;
    localparam int ROW_BYTES  = 16;
    localparam int ROW_W      = ROW_BYTES * 8;

    // on-chip bank geometry, 256 row words
    localparam int SRAM_AW    = 8;

    // instruction field widths
    localparam int ROW_SEL_W  = $clog2(MXU_ROWS);
    localparam int BYTE_SEL_W = $clog2(ROW_BYTES);
    localparam int LEN_W      = 3;
    localparam int CMD_ADDR_W = 12;

    // one int8 row, also the bank word
    typedef logic [ROW_W-1:0] row_t;

    // all output rows side by side, row 0 in the low bits
    typedef logic [MXU_ROWS-1:0][ROW_W-1:0] mxu_rows_t;

    // store instruction from the decoder
    typedef struct packed {
        // 0 iram, 1 wram
        logic                  target;
        logic [BYTE_SEL_W-1:0] start_x;
        logic [ROW_SEL_W-1:0]  start_y;
        logic [LEN_W-1:0]      len;
        // word address sits in the upper bits
        logic [CMD_ADDR_W-1:0] sram_addr;
    } store_cmd_t;

    // bank write port
    typedef struct packed {
        logic               en;
        logic [SRAM_AW-1:0] addr;
        row_t               data;
    } sram_wr_t;

    // bank read request
    typedef struct packed {
        logic               en;
        logic [SRAM_AW-1:0] addr;
    } sram_rd_t;

endpackage

`default_nettype wire

// ==== src/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 128
) (
    input  wire logic              clk,
    input  wire lsu_pkg::sram_wr_t wr,
    input  wire lsu_pkg::sram_rd_t rd,
    output logic [DATA_W-1:0]      rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] wr_data;

    // fit the bus fields to this bank's geometry
    assign wr_addr = ADDR_W'(wr.addr);
    assign rd_addr = ADDR_W'(rd.addr);
    assign wr_data = DATA_W'(wr.data);

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency, holds when idle
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdata <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/mxu_row_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxu_row_extract (
    input  wire lsu_pkg::mxu_rows_t             mxu_rows,
    input  wire logic [lsu_pkg::ROW_SEL_W-1:0]  row_sel,
    input  wire logic [lsu_pkg::BYTE_SEL_W-1:0] start_x,
    input  wire logic [lsu_pkg::LEN_W-1:0]      len,
    output lsu_pkg::row_t                       row_data
);

    lsu_pkg::row_t sel_row;
    lsu_pkg::row_t shifted;

    // byte offset to bit offset
    logic [lsu_pkg::BYTE_SEL_W+2:0] shift_bits;

    assign shift_bits = {start_x, 3'b000};

    // pick the row and move start_x down to byte 0
    always_comb begin
        sel_row = mxu_rows[row_sel];
        shifted = sel_row >> shift_bits;
    end

    // keep bytes 0..len, clear the rest
    always_comb begin
        for (int i = 0; i < lsu_pkg::ROW_BYTES; i++) begin
            if (i <= int'(len)) begin
                row_data[i*8 +: 8] = shifted[i*8 +: 8];
            end else begin
                row_data[i*8 +: 8] = 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu_store_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_store_ctrl (
    input  wire logic                             clk,
    input  wire logic                             rst,

    // decoder side
    input  wire logic                             cmd_vld,
    input  wire lsu_pkg::store_cmd_t              cmd,
    output logic                                  cmd_rdy,

    // matrix side
    input  wire logic                             mxu_data_rdy,
    input  wire lsu_pkg::row_t                    row_data,
    output logic [lsu_pkg::ROW_SEL_W-1:0]         row_sel,
    output logic [lsu_pkg::BYTE_SEL_W-1:0]        win_start_x,
    output logic [lsu_pkg::LEN_W-1:0]             win_len,

    // bank write ports
    output lsu_pkg::sram_wr_t                     iram_wr,
    output lsu_pkg::sram_wr_t                     wram_wr
);

    logic                               busy;
    lsu_pkg::store_cmd_t                cmd_q;
    logic [lsu_pkg::ROW_SEL_W-1:0]      row_cnt;
    logic [lsu_pkg::SRAM_AW-1:0]        addr_cnt;

    logic [lsu_pkg::ROW_SEL_W-1:0]      last_row;
    logic                               accept;
    logic                               wr_fire;
    logic                               last_wr;

    // a row moves whenever the matrix side has data
    assign wr_fire  = busy & mxu_data_rdy;

    // windows never wrap past row 15
    assign last_row = cmd_q.start_y + lsu_pkg::ROW_SEL_W'(cmd_q.len);
    assign last_wr  = wr_fire & (row_cnt == last_row);

    // ready again while the final row is written
    assign cmd_rdy  = ~busy | last_wr;
    assign accept   = cmd_vld & cmd_rdy;

    // busy flag
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (last_wr) begin
            busy <= 1'b0;
        end
    end

    // latched command
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    // row and word counters
    always_ff @(posedge clk) begin
        if (accept) begin
            row_cnt  <= cmd.start_y;
            addr_cnt <= cmd.sram_addr[lsu_pkg::CMD_ADDR_W-1 -: lsu_pkg::SRAM_AW];
        end else if (wr_fire) begin
            row_cnt  <= row_cnt + 1'b1;
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // window to the extractor, same cycle as the write
    assign row_sel     = row_cnt;
    assign win_start_x = cmd_q.start_x;
    assign win_len     = cmd_q.len;

    // steer by target, only one bank sees the enable
    always_comb begin
        iram_wr.en   = wr_fire & ~cmd_q.target;
        iram_wr.addr = addr_cnt;
        iram_wr.data = row_data;

        wram_wr.en   = wr_fire & cmd_q.target;
        wram_wr.addr = addr_cnt;
        wram_wr.data = row_data;
    end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire logic                clk,
    input  wire logic                rst,

    // decoder side
    input  wire logic                cmd_vld,
    input  wire lsu_pkg::store_cmd_t cmd,
    output logic                     cmd_rdy,

    // matrix unit rows and data ready level
    input  wire lsu_pkg::mxu_rows_t  mxu_rows,
    input  wire logic                mxu_data_rdy,

    // bank read ports
    input  wire lsu_pkg::sram_rd_t   iram_rd,
    input  wire lsu_pkg::sram_rd_t   wram_rd,
    output lsu_pkg::row_t            iram_rdata,
    output lsu_pkg::row_t            wram_rdata
);

    logic [lsu_pkg::ROW_SEL_W-1:0]  row_sel;
    logic [lsu_pkg::BYTE_SEL_W-1:0] win_start_x;
    logic [lsu_pkg::LEN_W-1:0]      win_len;
    lsu_pkg::row_t                  row_data;
    lsu_pkg::sram_wr_t              iram_wr;
    lsu_pkg::sram_wr_t              wram_wr;

    // accept, counters and write steering
    lsu_store_ctrl i_lsu_store_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cmd_vld      (cmd_vld),
        .cmd          (cmd),
        .cmd_rdy      (cmd_rdy),
        .mxu_data_rdy (mxu_data_rdy),
        .row_data     (row_data),
        .row_sel      (row_sel),
        .win_start_x  (win_start_x),
        .win_len      (win_len),
        .iram_wr      (iram_wr),
        .wram_wr      (wram_wr)
    );

    // row select and byte window cut
    mxu_row_extract i_mxu_row_extract (
        .mxu_rows (mxu_rows),
        .row_sel  (row_sel),
        .start_x  (win_start_x),
        .len      (win_len),
        .row_data (row_data)
    );

    // input bank
    sram_bank #(
        .ADDR_W (lsu_pkg::SRAM_AW),
        .DATA_W (lsu_pkg::ROW_W)
    ) i_iram (
        .clk   (clk),
        .wr    (iram_wr),
        .rd    (iram_rd),
        .rdata (iram_rdata)
    );

    // weight bank
    sram_bank #(
        .ADDR_W (lsu_pkg::SRAM_AW),
        .DATA_W (lsu_pkg::ROW_W)
    ) i_wram (
        .clk   (clk),
        .wr    (wram_wr),
        .rd    (wram_rd),
        .rdata (wram_rdata)
    );

endmodule

`default_nettype wire

// ==== test/lsu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_assert (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              mxu_data_rdy,
    input wire logic              cmd_rdy,
    input wire lsu_pkg::sram_wr_t iram_wr,
    input wire lsu_pkg::sram_wr_t wram_wr
);

    // only one bank takes a row per cycle
    one_bank_wr: assert property (@(posedge clk) disable iff (rst)
        !(iram_wr.en && wram_wr.en))
        else $error("iram and wram write enables high in the same cycle");

    // rows move only while the matrix unit has data
    wr_needs_data: assert property (@(posedge clk) disable iff (rst)
        (iram_wr.en || wram_wr.en) |-> mxu_data_rdy)
        else $error("bank write while mxu_data_rdy is low");

    // idle and ready right out of reset
    rdy_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> cmd_rdy)
        else $error("cmd_rdy low in the first cycle after reset");

endmodule

`default_nettype wire

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int DEPTH       = 1 << lsu_pkg::SRAM_AW;
    localparam int FILL_CMDS   = 2 * DEPTH / 8;
    localparam int PER_TEST    = 10;
    localparam int RAND_CMDS   = 4 * PER_TEST;
    // 40 cycles per store worst case, plus full bank sweeps and window readbacks
    localparam int CYCLE_LIMIT = (FILL_CMDS + RAND_CMDS) * 40 + 4 * DEPTH + RAND_CMDS * 20 + 100;

    logic                clk;
    logic                rst;
    logic                cmd_vld;
    lsu_pkg::store_cmd_t cmd;
    logic                cmd_rdy;
    lsu_pkg::mxu_rows_t  mxu_rows;
    logic                mxu_data_rdy;
    lsu_pkg::sram_rd_t   iram_rd;
    lsu_pkg::sram_rd_t   wram_rd;
    lsu_pkg::row_t       iram_rdata;
    lsu_pkg::row_t       wram_rdata;

    // shadow copies of both banks
    lsu_pkg::row_t iram_model [DEPTH];
    lsu_pkg::row_t wram_model [DEPTH];

    integer seed;
    int     cycles = 0;
    int     checks;
    int     errors;
    int     test_errs;

    lsu_top i_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .cmd_vld      (cmd_vld),
        .cmd          (cmd),
        .cmd_rdy      (cmd_rdy),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .iram_rd      (iram_rd),
        .wram_rd      (wram_rd),
        .iram_rdata   (iram_rdata),
        .wram_rdata   (wram_rdata)
    );

    bind lsu_store_ctrl lsu_assert i_lsu_assert (
        .clk          (clk),
        .rst          (rst),
        .mxu_data_rdy (mxu_data_rdy),
        .cmd_rdy      (cmd_rdy),
        .iram_wr      (iram_wr),
        .wram_wr      (wram_wr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a store or readback never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // bytes start_x..start_x+len moved to the bottom, upper bytes zero
    function automatic lsu_pkg::row_t window_word(lsu_pkg::row_t src, int start_x, int len);
        lsu_pkg::row_t w;
        w = '0;
        for (int i = 0; i <= len; i++) begin
            if (start_x + i < lsu_pkg::ROW_BYTES) begin
                w[i*8 +: 8] = src[(start_x + i)*8 +: 8];
            end
        end
        return w;
    endfunction

    // fill data tied to bank and full word address
    function automatic lsu_pkg::row_t fill_word(int bank, int addr);
        lsu_pkg::row_t w;
        for (int i = 0; i < lsu_pkg::ROW_BYTES; i++) begin
            w[i*8 +: 8] = 8'(addr) ^ 8'(i * 17) ^ ((bank == 1) ? 8'hA5 : 8'h3C);
        end
        return w;
    endfunction

    task automatic model_store(input lsu_pkg::store_cmd_t c, input lsu_pkg::mxu_rows_t rows);
        logic [7:0]    addr;
        lsu_pkg::row_t w;
        addr = c.sram_addr[11:4];
        for (int r = 0; r <= int'(c.len); r++) begin
            w = window_word(rows[int'(c.start_y) + r], int'(c.start_x), int'(c.len));
            if (c.target) begin
                wram_model[addr] = w;
            end else begin
                iram_model[addr] = w;
            end
            addr = addr + 8'd1;
        end
    endtask

    task automatic randomize_rows();
        for (int i = 0; i < lsu_pkg::MXU_ROWS; i++) begin
            for (int j = 0; j < lsu_pkg::ROW_W / 32; j++) begin
                mxu_rows[i][j*32 +: 32] = $random(seed);
            end
        end
    endtask

    // window kept inside the 16 x 16 matrix
    task automatic make_cmd(input logic target, output lsu_pkg::store_cmd_t c);
        int len;
        len = $unsigned($random(seed)) % 8;
        c.target    = target;
        c.len       = 3'(len);
        c.start_y   = 4'($unsigned($random(seed)) % (16 - len));
        c.start_x   = 4'($unsigned($random(seed)) % (16 - len));
        c.sram_addr = 12'($unsigned($random(seed)));
    endtask

    // called on a falling edge with the unit idle
    task automatic run_store(input lsu_pkg::store_cmd_t c, input bit toggle);
        int writes;
        bit done;
        writes = 0;
        done = 1'b0;
        cmd = c;
        cmd_vld = 1'b1;
        mxu_data_rdy = 1'b1;
        #1;
        if (!cmd_rdy) begin
            $display("store not accepted, cmd_rdy low while the unit is idle");
            test_errs++;
        end
        @(negedge clk);
        cmd_vld = 1'b0;
        model_store(c, mxu_rows);
        while (!done) begin
            mxu_data_rdy = toggle ? ($random(seed) % 4 != 0) : 1'b1;
            #1;
            if (mxu_data_rdy) begin
                writes++;
            end
            // high while busy only in the cycle of the last row
            done = cmd_rdy;
            @(negedge clk);
        end
        checks++;
        if (writes != int'(c.len) + 1) begin
            $display("ERR bank_writes exp %h got %h", int'(c.len) + 1, writes);
            test_errs++;
        end
    endtask

    task automatic read_word(input logic bank, input logic [7:0] addr, output lsu_pkg::row_t data);
        if (bank) begin
            wram_rd.en = 1'b1;
            wram_rd.addr = addr;
        end else begin
            iram_rd.en = 1'b1;
            iram_rd.addr = addr;
        end
        @(negedge clk);
        iram_rd.en = 1'b0;
        wram_rd.en = 1'b0;
        data = bank ? wram_rdata : iram_rdata;
    endtask

    task automatic check_range(input logic bank, input logic [7:0] start, input int n);
        lsu_pkg::row_t got;
        lsu_pkg::row_t exp;
        logic [7:0]    addr;
        string         name;
        name = bank ? "wram_rdata" : "iram_rdata";
        for (int i = 0; i < n; i++) begin
            addr = start + 8'(i);
            read_word(bank, addr, got);
            exp = bank ? wram_model[addr] : iram_model[addr];
            checks++;
            if (got !== exp) begin
                $display("ERR %s[%h] exp %h got %h", name, addr, exp, got);
                test_errs++;
            end
        end
    endtask

    // window plus the word after it, in both banks
    task automatic check_store(input lsu_pkg::store_cmd_t c);
        check_range(c.target, c.sram_addr[11:4], int'(c.len) + 2);
        check_range(~c.target, c.sram_addr[11:4], int'(c.len) + 2);
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, test_errs);
        end
        errors += test_errs;
        test_errs = 0;
    endtask

    initial begin
        lsu_pkg::store_cmd_t c;
        int waited;
        int prev_len;
        seed = 58;
        clk = 1'b0;
        rst = 1'b1;
        cmd_vld = 1'b0;
        cmd = '0;
        mxu_rows = '0;
        mxu_data_rdy = 1'b0;
        iram_rd = '0;
        wram_rd = '0;
        checks = 0;
        errors = 0;
        test_errs = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        #1;
        checks++;
        if (cmd_rdy !== 1'b1) begin
            $display("ERR cmd_rdy exp %h got %h", 1'b1, cmd_rdy);
            test_errs++;
        end
        finish_test(1, "ready after reset");
        @(negedge clk);

        // known contents in every word of both banks
        for (int b = 0; b < 2; b++) begin
            for (int base = 0; base < DEPTH; base += 8) begin
                c.target = (b == 1);
                c.start_x = 4'd0;
                c.start_y = 4'd0;
                c.len = 3'd7;
                c.sram_addr = 12'(base << 4);
                for (int r = 0; r < lsu_pkg::MXU_ROWS; r++) begin
                    mxu_rows[r] = fill_word(b, base + r);
                end
                run_store(c, 1'b0);
            end
        end
        check_range(1'b0, 8'd0, DEPTH);
        check_range(1'b1, 8'd0, DEPTH);
        finish_test(0, "bank fill");

        for (int n = 0; n < PER_TEST; n++) begin
            make_cmd(1'b0, c);
            randomize_rows();
            run_store(c, 1'b0);
            check_store(c);
        end
        finish_test(2, "iram stores");

        for (int n = 0; n < PER_TEST; n++) begin
            make_cmd(1'b1, c);
            randomize_rows();
            run_store(c, 1'b0);
            check_store(c);
        end
        finish_test(3, "wram stores");

        for (int n = 0; n < PER_TEST; n++) begin
            make_cmd(1'($random(seed)), c);
            randomize_rows();
            run_store(c, 1'b1);
            check_store(c);
        end
        finish_test(4, "back-pressure");

        // rows stay fixed over the whole burst
        randomize_rows();
        mxu_data_rdy = 1'b1;
        cmd_vld = 1'b1;
        prev_len = 0;
        for (int n = 0; n < PER_TEST; n++) begin
            make_cmd(1'($random(seed)), c);
            cmd = c;
            waited = 0;
            #1;
            while (!cmd_rdy) begin
                @(negedge clk);
                waited++;
                #1;
            end
            // next accept lands on the edge of the previous last row
            checks++;
            if (n > 0 && waited != prev_len) begin
                $display("ERR accept_gap exp %h got %h", prev_len, waited);
                test_errs++;
            end
            model_store(c, mxu_rows);
            prev_len = int'(c.len);
            @(negedge clk);
        end
        cmd_vld = 1'b0;
        #1;
        while (!cmd_rdy) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        check_range(1'b0, 8'd0, DEPTH);
        check_range(1'b1, 8'd0, DEPTH);
        finish_test(5, "back-to-back");

        $display("tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/lsu_pkg.sv
src/sram_bank.sv
src/mxu_row_extract.sv
src/lsu_store_ctrl.sv
src/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the load-store unit store path

TOP := lsu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

obj_dir/V$(TOP): build.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f build.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
